// ==== Bender.yml ====
package:
  name: rp_drive

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/rpRegPkg.sv
      - design/rpCtrlPkg.sv
      - design/rpDiskAddr.sv
      - design/rpCylAddr.sv
      - design/rpCmdCtrl.sv
      - design/rpDrive.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/rpDriveTb.sv

// ==== bench/rpDriveTb.sv ====
////////////////////
// Drive testbench with clock, reset and APB tasks
// Xorshift stimulus and disk address model
// Register, transfer, overflow and decode checks
////////////////////

`timescale 1ns/1ps

`include "rp_defines.svh"

module rpDriveTb
   import rpRegPkg::*;
   import rpCtrlPkg::*;
();

   logic   clk;
   logic   rstN;
   logic   psel;
   logic   penable;
   logic   pwrite;
   apbAddr paddr;
   regWord pwdata;
   regWord prdata;
   logic   pslverr;

   // Model of the drive registers
   sectAddr  mSect;
   trkAddr   mTrk;
   cylAddr   mCyl;
   sectCount mCount;
   logic     mErr;

   logic [31:0] rngState;
   int          checks;
   int          errors;
   int          timeouts;

   rpDrive dut (
      .clk     (clk),
      .rstN    (rstN),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pslverr (pslverr)
   );

   // 4 ns clock
   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////
   // Random numbers
   ////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Next value below range
   function automatic int unsigned rnd(input int unsigned range);
      rngState = xorshift32(rngState);
      return rngState % range;
   endfunction

   ////////////////////
   // APB access
   ////////////////////

   // Setup and access phases with a mid-access sample
   task automatic apbWrite(input apbAddr a, input regWord d, output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= a;
      pwdata  <= d;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      err = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apbRead(input apbAddr a, output regWord d, output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= a;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      d   = prdata;
      err = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   // Write with the error response dropped
   task automatic regWrite(input apbAddr a, input regWord d);
      logic err;
      apbWrite(a, d, err);
   endtask

   // CS write with go set
   task automatic command(input rpCmd c);
      regWrite(`RP_ADDR_CS, {12'd0, c, 1'b1});
   endtask

   function automatic logic isMapped(input apbAddr a);
      return (a == `RP_ADDR_CS) || (a == `RP_ADDR_DA) || (a == `RP_ADDR_DC)
             || (a == `RP_ADDR_SC) || (a == `RP_ADDR_ST);
   endfunction

   ////////////////////
   // Checking
   ////////////////////

   task automatic checkEq(input string name, input regWord exp, input regWord act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("ERR %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // Compare all readable registers of an idle drive with the model
   task automatic checkRegs(input string name);
      regWord d;
      logic   err;
      apbRead(`RP_ADDR_DA, d, err);
      checkEq($sformatf("%s DA", name), {2'b00, mTrk, 2'b00, mSect}, d);
      checkEq($sformatf("%s DA pslverr", name), 16'd0, {15'd0, err});
      apbRead(`RP_ADDR_DC, d, err);
      checkEq($sformatf("%s DC", name), {6'd0, mCyl}, d);
      checkEq($sformatf("%s DC pslverr", name), 16'd0, {15'd0, err});
      apbRead(`RP_ADDR_SC, d, err);
      checkEq($sformatf("%s SC", name), {8'd0, mCount}, d);
      checkEq($sformatf("%s SC pslverr", name), 16'd0, {15'd0, err});
      apbRead(`RP_ADDR_ST, d, err);
      checkEq($sformatf("%s ST", name), {1'b0, mErr, 6'd0, 1'b1, 7'd0}, d);
      checkEq($sformatf("%s ST pslverr", name), 16'd0, {15'd0, err});
   endtask

   // Poll ST until ready or the poll limit
   task automatic waitReady();
      regWord st;
      logic   err;
      int     polls;
      polls = 0;
      apbRead(`RP_ADDR_ST, st, err);
      while (!st[7] && polls < 100)
      begin
         apbRead(`RP_ADDR_ST, st, err);
         polls++;
      end
      if (!st[7])
      begin
         timeouts++;
         $display("Timeout: drive still busy after %0d status polls", polls);
      end
   endtask

   ////////////////////
   // Address model
   ////////////////////

   // One sector step with track and cylinder carry
   task automatic modelStep(output logic ovf);
      ovf = 1'b0;
      if (mSect != `RP_LAST_SECT)
         mSect = mSect + 1'b1;
      else
      begin
         mSect = '0;
         if (mTrk != `RP_LAST_TRK)
            mTrk = mTrk + 1'b1;
         else
         begin
            mTrk = '0;
            if (mCyl != `RP_LAST_CYL)
               mCyl = mCyl + 1'b1;
            else
            begin
               mCyl = '0;
               ovf  = 1'b1;
            end
         end
      end
   endtask

   // Whole read command that stops on overflow
   // Ignored while the error flag is set
   task automatic modelRead();
      logic ovf;
      while (mCount != 0 && !mErr)
      begin
         modelStep(ovf);
         if (ovf)
            mErr = 1'b1;
         else
            mCount = mCount - 1'b1;
      end
   endtask

   task automatic setStart(input sectAddr s, input trkAddr t, input cylAddr c);
      regWrite(`RP_ADDR_DA, {2'b00, t, 2'b00, s});
      regWrite(`RP_ADDR_DC, {6'd0, c});
      mSect = s;
      mTrk  = t;
      mCyl  = c;
   endtask

   task automatic setCount(input sectCount n);
      regWrite(`RP_ADDR_SC, {8'd0, n});
      mCount = n;
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial
   begin
      regWord d;
      logic   err;
      apbAddr a;
      int     i;
      rngState = 32'ha605511e;
      checks   = 0;
      errors   = 0;
      timeouts = 0;
      mSect    = '0;
      mTrk     = '0;
      mCyl     = '0;
      mCount   = '0;
      mErr     = 1'b0;
      rstN    <= 1'b0;
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= '0;
      pwdata  <= '0;
      repeat (5) @(posedge clk);
      rstN <= 1'b1;
      checkRegs("reset");

      // Field masking on full random words
      for (i = 0; i < 20; i++)
      begin
         d = regWord'(rnd(65536));
         regWrite(`RP_ADDR_DA, d);
         mSect = d[5:0];
         mTrk  = d[13:8];
         d = regWord'(rnd(65536));
         regWrite(`RP_ADDR_DC, d);
         mCyl = d[9:0];
         d = regWord'(rnd(65536));
         regWrite(`RP_ADDR_SC, d);
         mCount = d[7:0];
         checkRegs("masking");
      end

      // Preset clears the address and drive clear keeps it
      command(cmdPreset);
      mSect = '0;
      mTrk  = '0;
      mCyl  = '0;
      checkRegs("preset");
      apbRead(`RP_ADDR_CS, d, err);
      checkEq("cs readback", 16'h0002, d);
      setStart(sectAddr'(rnd(22)), trkAddr'(rnd(19)), cylAddr'(rnd(815)));
      command(cmdDrvClr);
      checkRegs("drive clear");

      // Random transfers including count zero
      for (i = 0; i < 12; i++)
      begin
         setStart(sectAddr'(rnd(22)), trkAddr'(rnd(19)), cylAddr'(rnd(815)));
         setCount(sectCount'(rnd(13)));
         command(cmdRead);
         modelRead();
         waitReady();
         checkRegs("transfer");
      end

      // Host writes while busy are lost
      for (i = 0; i < 6; i++)
      begin
         setStart(sectAddr'(rnd(22)), trkAddr'(rnd(19)), cylAddr'(rnd(815)));
         setCount(sectCount'(4 + rnd(8)));
         command(cmdRead);
         apbRead(`RP_ADDR_ST, d, err);
         checkEq("busy ready", 16'd0, {15'd0, d[7]});
         regWrite(`RP_ADDR_DA, regWord'(rnd(65536)));
         regWrite(`RP_ADDR_DC, regWord'(rnd(65536)));
         modelRead();
         waitReady();
         checkRegs("busy writes");
      end

      // Overflow off the last cylinder
      setStart(sectAddr'(`RP_LAST_SECT - rnd(3)), trkAddr'(`RP_LAST_TRK),
               cylAddr'(`RP_LAST_CYL));
      setCount(sectCount'(4 + rnd(5)));
      command(cmdRead);
      modelRead();
      waitReady();
      checkRegs("overflow");
      // Read refused while the error is set
      command(cmdRead);
      modelRead();
      checkRegs("refused read");
      command(cmdDrvClr);
      mErr = 1'b0;
      checkRegs("error cleared");
      command(cmdRead);
      modelRead();
      waitReady();
      checkRegs("after clear");

      // Unmapped offsets
      for (i = 0; i < 10; i++)
      begin
         a = apbAddr'(rnd(32));
         if (isMapped(a))
            a = a + 1'b1;
         apbRead(a, d, err);
         checkEq("unmapped read pslverr", 16'd1, {15'd0, err});
         checkEq("unmapped prdata", 16'd0, d);
         apbWrite(a, regWord'(rnd(65536)), err);
         checkEq("unmapped write pslverr", 16'd1, {15'd0, err});
      end
      checkRegs("unmapped");

      $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// ==== design/rpCmdCtrl.sv ====
////////////////////
// APB register decode and read mux
// Sector count, last command, error flag
// Read transfer state machine
////////////////////

`timescale 1ns/1ps

`include "rp_defines.svh"

module rpCmdCtrl
   import rpRegPkg::*;
   import rpCtrlPkg::*;
(
   input  logic   clk,
   input  logic   rstN,
   input  logic   psel,
   input  logic   penable,
   input  logic   pwrite,
   input  apbAddr paddr,
   input  regWord pwdata,
   input  regWord daValue,
   input  regWord dcValue,
   input  logic   addrOvf,
   output regWord prdata,
   output logic   pslverr,
   output logic   wrDa,
   output logic   wrDc,
   output regWord wrData,
   output logic   preset,
   output logic   incSect
);

   localparam int CycW = (`RP_SECT_CYCLES > 1) ? $clog2(`RP_SECT_CYCLES) : 1;
   localparam logic [CycW-1:0] LastCyc = CycW'(`RP_SECT_CYCLES - 1);

   ctrlState        state;
   logic [CycW-1:0] cyc;
   sectCount        count;
   rpCmd            lastCmd;
   logic            errFlag;

   logic   access;
   logic   wrAcc;
   logic   ready;
   logic   addrOk;
   regWord rdMux;
   logic   go;
   rpCmd   wrCmd;
   logic   csTake;
   logic   drvClr;
   logic   startRd;

   ////////////////////
   // Bus decode
   ////////////////////

   assign access = psel && penable;
   assign wrAcc  = access && pwrite;
   assign ready  = (state == stIdle);

   // Register select and read data
   always_comb
   begin
      addrOk = 1'b1;
      rdMux  = '0;
      case (paddr)
         `RP_ADDR_CS: rdMux = {12'd0, lastCmd, 1'b0};
         `RP_ADDR_DA: rdMux = daValue;
         `RP_ADDR_DC: rdMux = dcValue;
         `RP_ADDR_SC: rdMux = {8'd0, count};
         `RP_ADDR_ST: rdMux = {1'b0, errFlag, 6'd0, ready, 7'd0};
         default:     addrOk = 1'b0;
      endcase
   end

   // Zero outside the access phase
   assign prdata  = (access && addrOk) ? rdMux : '0;
   assign pslverr = access && !addrOk;

   // Address writes only while idle
   assign wrData = pwdata;
   assign wrDa   = wrAcc && ready && (paddr == `RP_ADDR_DA);
   assign wrDc   = wrAcc && ready && (paddr == `RP_ADDR_DC);

   // CS writes need an idle drive except drive clear
   assign go      = pwdata[0];
   assign wrCmd   = rpCmd'(pwdata[3:1]);
   assign csTake  = wrAcc && (paddr == `RP_ADDR_CS)
                    && (ready || (go && (wrCmd == cmdDrvClr)));
   assign preset  = csTake && go && (wrCmd == cmdPreset);
   assign drvClr  = csTake && go && (wrCmd == cmdDrvClr);
   assign startRd = csTake && go && (wrCmd == cmdRead)
                    && (count != '0) && !errFlag;

   assign incSect = (state == stStep);

   ////////////////////
   // Transfer sequencer
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         state   <= stIdle;
         cyc     <= '0;
         count   <= '0;
         lastCmd <= cmdNop;
         errFlag <= 1'b0;
      end
      else
      begin
         if (csTake)
            lastCmd <= wrCmd;
         if (wrAcc && ready && (paddr == `RP_ADDR_SC))
            count <= pwdata[7:0];
         if (drvClr)
            errFlag <= 1'b0;

         case (state)
            stIdle:
            begin
               if (startRd)
               begin
                  cyc   <= '0;
                  state <= stSector;
               end
            end
            stSector:
            begin
               // Wait out one sector time
               cyc <= cyc + 1'b1;
               if (cyc == LastCyc)
                  state <= stStep;
            end
            stStep:
            begin
               cyc <= '0;
               if (addrOvf)
               begin
                  // Abort with the unfinished sectors left in count
                  errFlag <= 1'b1;
                  state   <= stIdle;
               end
               else
               begin
                  count <= count - 1'b1;
                  state <= (count == 8'd1) ? stIdle : stSector;
               end
            end
            default:
               state <= stIdle;
         endcase
      end
   end

   // A step always has a sector left and no pending error
   assert property (@(posedge clk) disable iff (!rstN)
      incSect |-> (count != '0) && !errFlag)
      else $error("Sector step with no sector left or with the error set");

endmodule

// ==== design/rpCtrlPkg.sv ====
////////////////////
// Drive command codes
// Controller state encoding
////////////////////

package rpCtrlPkg;

   // Function codes from CS bits 3:1
   // Codes 4 to 7 fall through as no-op
   typedef enum logic [2:0] {
      cmdNop    = 3'd0,
      cmdPreset = 3'd1,
      cmdDrvClr = 3'd2,
      cmdRead   = 3'd3
   } rpCmd;

   // Transfer sequencer
   typedef enum logic [1:0] {
      stIdle,
      stSector,
      stStep
   } ctrlState;

endpackage

// ==== design/rpCylAddr.sv ====
////////////////////
// Desired cylinder register
// Host load, carry increment, overflow flag
////////////////////

`timescale 1ns/1ps

`include "rp_defines.svh"

module rpCylAddr
   import rpRegPkg::*;
#(
   parameter cylAddr lastCyl = `RP_LAST_CYL
)
(
   input  logic   clk,
   input  logic   rstN,
   input  logic   preset,
   input  logic   wrDc,
   input  regWord wrData,
   input  logic   incSect,
   input  logic   cylCarry,
   output regWord dcValue,
   output logic   addrOvf
);

   cylAddr cyl;

   // Step that carries out of the track field
   logic cylStep;
   logic cylWrap;

   assign cylStep = incSect && cylCarry;
   assign cylWrap = (cyl == lastCyl);

   // Cylinder register
   always_ff @(posedge clk)
   begin
      if (!rstN || preset)
         cyl <= '0;
      else if (wrDc)
         cyl <= wrData[`RP_CYL_W-1:0];
      else if (cylStep)
         cyl <= cylWrap ? '0 : cyl + 1'b1;
   end

   // Stepping off the last cylinder
   assign addrOvf = cylStep && cylWrap;

   assign dcValue = {6'd0, cyl};

   // Carry from an in-range cylinder stays in range
   assert property (@(posedge clk) disable iff (!rstN)
      cylStep && (cyl <= lastCyl) |=> (cyl <= lastCyl))
      else $error("Cylinder stepped past the last cylinder");

endmodule

// ==== design/rpDiskAddr.sv ====
////////////////////
// Sector and track address register
// Host load, sector step with track wrap
// Carry towards the cylinder register
////////////////////

`timescale 1ns/1ps

`include "rp_defines.svh"

module rpDiskAddr
   import rpRegPkg::*;
#(
   parameter sectAddr lastSect = `RP_LAST_SECT,
   parameter trkAddr  lastTrk  = `RP_LAST_TRK
)
(
   input  logic   clk,
   input  logic   rstN,
   input  logic   preset,
   input  logic   wrDa,
   input  regWord wrData,
   input  logic   incSect,
   output regWord daValue,
   output logic   cylCarry
);

   // Current sector and track
   sectAddr sect;
   trkAddr  trk;

   // Fields sitting at their last value
   logic sectWrap;
   logic trkWrap;

   assign sectWrap = (sect == lastSect);
   assign trkWrap  = (trk == lastTrk);

   ////////////////////
   // Address update
   ////////////////////

   // Preset beats a write and a write beats a step
   always_ff @(posedge clk)
   begin
      if (!rstN || preset)
      begin
         sect <= '0;
         trk  <= '0;
      end
      else if (wrDa)
      begin
         // Sector in bits 5:0, track in bits 13:8
         sect <= wrData[`RP_SECT_W-1:0];
         trk  <= wrData[8 +: `RP_TRK_W];
      end
      else if (incSect)
      begin
         sect <= sectWrap ? '0 : sect + 1'b1;
         // Track moves only when the sector rolls over
         if (sectWrap)
         begin
            trk <= trkWrap ? '0 : trk + 1'b1;
         end
      end
   end

   // Next step would roll both fields
   assign cylCarry = sectWrap && trkWrap;

   // Unused bits read as zero
   assign daValue = {2'b00, trk, 2'b00, sect};

   ////////////////////
   // Checks
   ////////////////////

   // A step from an in-range address stays in range
   assert property (@(posedge clk) disable iff (!rstN)
      incSect && (sect <= lastSect) && (trk <= lastTrk)
      |=> (sect <= lastSect) && (trk <= lastTrk))
      else $error("Disk address stepped past the geometry");

endmodule

// ==== design/rpDrive.sv ====
////////////////////
// Drive top level
// APB controller with sector, track and cylinder registers
////////////////////

`timescale 1ns/1ps

`include "rp_defines.svh"

module rpDrive
   import rpRegPkg::*;
(
   input  logic   clk,
   input  logic   rstN,
   input  logic   psel,
   input  logic   penable,
   input  logic   pwrite,
   input  apbAddr paddr,
   input  regWord pwdata,
   output regWord prdata,
   output logic   pslverr
);

   // Controller strobes
   logic   wrDa;
   logic   wrDc;
   regWord wrData;
   logic   preset;
   logic   incSect;

   // Address state back to the controller
   regWord daValue;
   regWord dcValue;
   logic   cylCarry;
   logic   addrOvf;

   rpCmdCtrl ctrl (
      .clk     (clk),
      .rstN    (rstN),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .daValue (daValue),
      .dcValue (dcValue),
      .addrOvf (addrOvf),
      .prdata  (prdata),
      .pslverr (pslverr),
      .wrDa    (wrDa),
      .wrDc    (wrDc),
      .wrData  (wrData),
      .preset  (preset),
      .incSect (incSect)
   );

   // Sector and track
   rpDiskAddr #(
      .lastSect (sectAddr'(`RP_LAST_SECT)),
      .lastTrk  (trkAddr'(`RP_LAST_TRK))
   ) diskAddr (
      .clk      (clk),
      .rstN     (rstN),
      .preset   (preset),
      .wrDa     (wrDa),
      .wrData   (wrData),
      .incSect  (incSect),
      .daValue  (daValue),
      .cylCarry (cylCarry)
   );

   // Cylinder fed by the carry out of the track
   rpCylAddr #(
      .lastCyl (cylAddr'(`RP_LAST_CYL))
   ) cylAddrReg (
      .clk      (clk),
      .rstN     (rstN),
      .preset   (preset),
      .wrDc     (wrDc),
      .wrData   (wrData),
      .incSect  (incSect),
      .cylCarry (cylCarry),
      .dcValue  (dcValue),
      .addrOvf  (addrOvf)
   );

endmodule

// ==== design/rpRegPkg.sv ====
////////////////////
// Register word and disk address field types
// Bus address and transfer length types
////////////////////

`include "rp_defines.svh"

package rpRegPkg;

   // One 16-bit drive register
   typedef logic [15:0] regWord;

   // Disk address fields
   typedef logic [`RP_SECT_W-1:0] sectAddr;
   typedef logic [`RP_TRK_W-1:0]  trkAddr;
   typedef logic [`RP_CYL_W-1:0]  cylAddr;

   // APB byte address
   typedef logic [`RP_APB_AW-1:0] apbAddr;

   // Sectors left in a transfer
   typedef logic [7:0] sectCount;

endpackage

// ==== include/rp_defines.svh ====
////////////////////
// Register offsets on the APB port
// Address field widths and drive geometry
// Sector time in clock cycles
////////////////////

`ifndef RP_DEFINES_SVH
`define RP_DEFINES_SVH

// APB byte offsets
`define RP_ADDR_CS 5'h00
`define RP_ADDR_DA 5'h04
`define RP_ADDR_DC 5'h08
`define RP_ADDR_SC 5'h0C
`define RP_ADDR_ST 5'h10

// Bus address width
`define RP_APB_AW 5

// Disk address field widths
`define RP_SECT_W 6
`define RP_TRK_W  6
`define RP_CYL_W  10

// Last valid sector, track and cylinder
`define RP_LAST_SECT 21
`define RP_LAST_TRK  18
`define RP_LAST_CYL  814

// Clocks spent over one sector
`define RP_SECT_CYCLES 4

`endif

// ==== list.f ====
+incdir+include
design/rpRegPkg.sv
design/rpCtrlPkg.sv
design/rpDiskAddr.sv
design/rpCylAddr.sv
design/rpCmdCtrl.sv
design/rpDrive.sv
bench/rpDriveTb.sv
